//--- dv/link_cases.txt
# columns: case name, buttons (attack up down left right), turns to repeat,
# then expected x, y and facing (0 up, 1 down, 2 left, 3 right) after the last turn
no_button       00000  1  127  88  1
attack_only     10000  1  127  88  1
step_down       00100  1  127  89  1
step_left       00010  1  126  89  2
step_right      00001  1  127  89  3
step_up         01000  1  127  88  0
prio_attack_up  11000  1  127  88  0
prio_up_down    01100  1  127  87  0
prio_down_left  00110  1  127  88  1
prio_left_right 00011  1  126  88  2
prio_all        11111  1  126  88  2
walk_right      00001 18  144  88  3
walk_up         01000 16  144  72  0
walk_under      00001 16  160  72  3
obst_below      01000  1  160  72  0
walk_back       00010 16  144  72  2
step_beside     01000  1  144  71  0
obst_side       00001  1  144  71  3
walk_to_top     01000 63  144   8  0
edge_top        01000  1  144   8  0
along_top       00010  1  143   8  2
edge_prio       01010  1  143   8  0

//--- dv/link_checker.sv
// testbench monitor; predicts every frame buffer write from the sprite rules and counts errors
`timescale 1ns/1ps

`include "game_settings.svh"

module link_checker
	import game_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    fb_req,
	input  pixel_t  fb_pix,
	input  logic    fb_ack,
	input  pos_t    char_pos,
	input  facing_e char_facing,
	output int      value_errors,
	output int      protocol_errors,
	output int      other_errors
);

	// only the 12x12 interior of a sprite is opaque
	localparam int INTERIOR = `SPRITE_SIZE - 2 * `SPRITE_BORDER;
	localparam int WRITES_PER_TURN = INTERIOR * INTERIOR;

	string  case_name;
	int     writes;
	logic   req_q;
	logic   ack_q;
	pixel_t pix_q;

	initial
	begin
		value_errors    = 0;
		protocol_errors = 0;
		other_errors    = 0;
		case_name       = "none";
		writes          = 0;
	end

	// sheet order is down, left, up, right; colour is 10 plus 10 per sheet slot
	function automatic logic [5:0] facing_colour(facing_e f);
		int slot;
		case (f)
			FACE_DOWN:
				slot = 0;
			FACE_LEFT:
				slot = 1;
			FACE_UP:
				slot = 2;
			default:
				slot = 3;
		endcase
		return 6'(10 + 10 * slot);
	endfunction

	task automatic start_case(input string name);
		case_name = name;
	endtask

	task automatic report_problem(input string msg);
		$display("%s (case %s)", msg, case_name);
		other_errors++;
	endtask

	// writes arrive in scan order, rows top to bottom, columns left to right
	task automatic check_write(input pixel_t p);
		int     row;
		int     col;
		pixel_t exp;
		if (writes >= WRITES_PER_TURN)
		begin
			$display("extra frame buffer write in case %s", case_name);
			protocol_errors++;
		end
		else
		begin
			row        = `SPRITE_BORDER + writes / INTERIOR;
			col        = `SPRITE_BORDER + writes % INTERIOR;
			exp.x      = char_pos.x + 9'(col);
			exp.y      = char_pos.y + 8'(row);
			exp.colour = facing_colour(char_facing);
			if (p !== exp)
			begin
				// values given as x/y/colour
				$display("error %s: write %0d expected %0d/%0d/%0d actual %0d/%0d/%0d",
					case_name, writes, exp.x, exp.y, exp.colour, p.x, p.y, p.colour);
				value_errors++;
			end
		end
		writes++;
	endtask

	// called once the bus is quiet after a turn
	task automatic check_writes();
		if (writes != WRITES_PER_TURN)
		begin
			$display("error %s: frame buffer writes expected %0d actual %0d",
				case_name, WRITES_PER_TURN, writes);
			value_errors++;
		end
		writes = 0;
	endtask

	task automatic check_state(input int x, input int y, input facing_e f);
		if (char_pos.x !== 9'(x) || char_pos.y !== 8'(y))
		begin
			$display("error %s: position expected (%0d,%0d) actual (%0d,%0d)",
				case_name, x, y, char_pos.x, char_pos.y);
			value_errors++;
		end
		if (char_facing !== f)
		begin
			$display("error %s: facing expected %0d actual %0d", case_name, f, char_facing);
			value_errors++;
		end
	endtask

	// four-phase watch on the frame buffer bus
	always @(posedge clock)
	begin
		if (reset)
		begin
			req_q = 1'b0;
			ack_q = 1'b0;
		end
		else
		begin
			if (fb_req && !req_q && fb_ack)
			begin
				$display("frame buffer request raised before ack fell in case %s", case_name);
				protocol_errors++;
			end
			if (fb_req && req_q && fb_pix !== pix_q)
			begin
				$display("frame buffer pixel changed during a request in case %s", case_name);
				protocol_errors++;
			end
			if (fb_req && req_q && ack_q)
			begin
				$display("frame buffer request still high a cycle after ack in case %s", case_name);
				protocol_errors++;
			end
			if (!fb_req && req_q && !ack_q)
			begin
				$display("frame buffer request dropped without ack in case %s", case_name);
				protocol_errors++;
			end
			// a write counts on the first cycle with both req and ack
			if (fb_req && fb_ack && !ack_q)
				check_write(fb_pix);
			req_q = fb_req;
			ack_q = fb_ack;
			pix_q = fb_pix;
		end
	end

endmodule

//--- dv/link_tb.sv
// testbench top; reads the case file, runs keypad turns and answers frame buffer writes
`timescale 1ns/1ps

`include "game_settings.svh"

module link_tb
	import game_pkg::*;
();

	// cycles allowed for each kind of wait
	localparam int ACK_LIMIT  = 20;
	localparam int TURN_LIMIT = 10000;
	localparam int BUS_LIMIT  = 50;

	logic     clock;
	logic     reset;
	logic     cmd_req;
	buttons_t cmd_buttons;
	logic     cmd_ack;
	logic     fb_req;
	pixel_t   fb_pix;
	logic     fb_ack;
	pos_t     char_pos;
	facing_e  char_facing;
	logic     turn_done;
	int       value_errors;
	int       protocol_errors;
	int       other_errors;
	integer   seed = 64;

	link_top dut_i (
		.clock       (clock),
		.reset       (reset),
		.cmd_req     (cmd_req),
		.cmd_buttons (cmd_buttons),
		.cmd_ack     (cmd_ack),
		.fb_req      (fb_req),
		.fb_pix      (fb_pix),
		.fb_ack      (fb_ack),
		.char_pos    (char_pos),
		.char_facing (char_facing),
		.turn_done   (turn_done)
	);

	link_checker checker_i (
		.clock           (clock),
		.reset           (reset),
		.fb_req          (fb_req),
		.fb_pix          (fb_pix),
		.fb_ack          (fb_ack),
		.char_pos        (char_pos),
		.char_facing     (char_facing),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors),
		.other_errors    (other_errors)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// frame buffer slave, ack after 0 to 7 idle cycles
	initial
	begin : fb_responder
		int delay;
		int n;
		fb_ack <= 1'b0;
		forever
		begin
			@(posedge clock);
			if (fb_req && !fb_ack && !reset)
			begin
				delay = $unsigned($random(seed)) % 8;
				repeat (delay)
					@(posedge clock);
				fb_ack <= 1'b1;
				// writer drops req the cycle after it sees ack
				n = 0;
				@(posedge clock);
				while (fb_req && n < BUS_LIMIT)
				begin
					@(posedge clock);
					n++;
				end
				if (fb_req)
					checker_i.report_problem("frame buffer request stayed high after ack");
				else
				begin
					// ack is released 0 to 7 cycles after req falls
					delay = $unsigned($random(seed)) % 8;
					repeat (delay)
						@(posedge clock);
				end
				fb_ack <= 1'b0;
			end
		end
	end

	// one keypad handshake, then the whole turn until the bus is quiet
	task automatic run_turn(input buttons_t b, output bit turn_ok);
		int n;
		turn_ok = 1'b0;
		@(posedge clock);
		cmd_buttons <= b;
		cmd_req     <= 1'b1;
		n = 0;
		while (!cmd_ack && n < ACK_LIMIT)
		begin
			@(posedge clock);
			n++;
		end
		if (!cmd_ack)
			checker_i.report_problem("timeout waiting for keypad ack to rise");
		else
		begin
			cmd_req <= 1'b0;
			n = 0;
			while (cmd_ack && n < ACK_LIMIT)
			begin
				@(posedge clock);
				n++;
			end
			if (cmd_ack)
				checker_i.report_problem("timeout waiting for keypad ack to fall");
			else
			begin
				// the draw alone takes hundreds of cycles
				n = 0;
				while (!turn_done && n < TURN_LIMIT)
				begin
					@(posedge clock);
					n++;
				end
				if (!turn_done)
					checker_i.report_problem("timeout waiting for turn_done");
				else
				begin
					n = 0;
					while ((fb_req || fb_ack) && n < BUS_LIMIT)
					begin
						@(posedge clock);
						n++;
					end
					if (fb_req || fb_ack)
						checker_i.report_problem("timeout waiting for idle frame buffer bus");
					else
					begin
						checker_i.check_writes();
						turn_ok = 1'b1;
					end
				end
			end
		end
	endtask

	initial
	begin : main
		int         fd;
		int         reps;
		int         x;
		int         y;
		int         f;
		int         cases;
		logic [4:0] btn;
		string      line;
		string      name;
		bit         ok;
		reset       <= 1'b1;
		cmd_req     <= 1'b0;
		cmd_buttons <= '0;
		ok    = 1'b1;
		cases = 0;
		repeat (5)
			@(posedge clock);
		reset <= 1'b0;
		// init takes one cycle, then the sequencer idles
		repeat (2)
			@(posedge clock);
		checker_i.start_case("after_reset");
		checker_i.check_state(`START_X, `START_Y, FACE_DOWN);
		fd = $fopen("dv/link_cases.txt", "r");
		if (fd == 0)
			checker_i.report_problem("could not open dv/link_cases.txt");
		else
		begin
			while (ok && $fgets(line, fd) != 0)
			begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				if ($sscanf(line, "%s %b %d %d %d %d", name, btn, reps, x, y, f) != 6)
				begin
					checker_i.report_problem("malformed line in case file");
					ok = 1'b0;
				end
				else
				begin
					checker_i.start_case(name);
					cases++;
					for (int i = 0; i < reps && ok; i++)
						run_turn(btn, ok);
					if (ok)
						checker_i.check_state(x, y, facing_e'(f[1:0]));
				end
			end
			$fclose(fd);
			if (cases == 0)
				checker_i.report_problem("case file held no cases");
		end
		$display("%0d cases run, errors: %0d value, %0d protocol, %0d other",
			cases, value_errors, protocol_errors, other_errors);
		if (value_errors + protocol_errors + other_errors == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- include/game_settings.svh
// game constants for screen, arena, obstacle, start and sprite; include in any RTL file using them
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// visible playfield
`define SCREEN_W 320
`define SCREEN_H 240

// allowed range for the sprite's top-left corner
`define ARENA_X_MIN 8
`define ARENA_X_MAX 296
`define ARENA_Y_MIN 8
`define ARENA_Y_MAX 216

// fixed obstacle, top-left corner and size
`define OBST_X 160
`define OBST_Y 40
`define OBST_W 32
`define OBST_H 32

// corner after init
`define START_X 127
`define START_Y 88

// sprite cell geometry
`define SPRITE_SIZE 16
`define SPRITE_BORDER 2
`define TRANSPARENT 63

`endif

//--- rtl/collision_check.sv
// combinational step check against the arena box and the fixed obstacle
`timescale 1ns/1ps

`include "game_settings.svh"

module collision_check
	import game_pkg::*;
(
	input  pos_t    position,
	input  action_e action,
	output logic    blocked
);

	always_comb
	begin
		int nx;
		int ny;
		logic move;
		logic outside;
		logic overlap;

		// candidate corner, signed ints so a step below zero stays negative
		nx   = int'(position.x);
		ny   = int'(position.y);
		move = 1'b1;
		case (action)
			ACT_UP:
				ny = ny - 1;
			ACT_DOWN:
				ny = ny + 1;
			ACT_LEFT:
				nx = nx - 1;
			ACT_RIGHT:
				nx = nx + 1;
			// attack and none never move
			default:
				move = 1'b0;
		endcase

		outside = (nx < `ARENA_X_MIN) || (nx > `ARENA_X_MAX) ||
			(ny < `ARENA_Y_MIN) || (ny > `ARENA_Y_MAX);

		// box intersection on both axes
		overlap = (nx < `OBST_X + `OBST_W) && (nx + `SPRITE_SIZE > `OBST_X) &&
			(ny < `OBST_Y + `OBST_H) && (ny + `SPRITE_SIZE > `OBST_Y);

		blocked = move && (outside || overlap);
	end

endmodule

//--- rtl/command_capture.sv
// keypad input side; completes the req/ack handshake and holds one decoded action for the sequencer
`timescale 1ns/1ps

module command_capture
	import game_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     cmd_req,
	input  buttons_t cmd_buttons,
	output logic     cmd_ack,
	input  logic     action_take,
	output logic     action_valid,
	output action_e  action
);

	// fixed priority: attack first, then up, down, left, right
	function automatic action_e encode(buttons_t b);
		if (b.attack)
			return ACT_ATTACK;
		if (b.up)
			return ACT_UP;
		if (b.down)
			return ACT_DOWN;
		if (b.left)
			return ACT_LEFT;
		if (b.right)
			return ACT_RIGHT;
		return ACT_NONE;
	endfunction

	logic latch;

	// new request only when idle on the bus and nothing pending
	assign latch = cmd_req && !cmd_ack && !action_valid;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			cmd_ack      <= 1'b0;
			action_valid <= 1'b0;
			action       <= ACT_NONE;
		end
		else
		begin
			if (latch)
			begin
				action       <= encode(cmd_buttons);
				action_valid <= 1'b1;
				cmd_ack      <= 1'b1;
			end
			else
			begin
				// keypad released req, finish the four phases
				if (cmd_ack && !cmd_req)
					cmd_ack <= 1'b0;
				// sequencer consumed it in the register step
				if (action_take)
					action_valid <= 1'b0;
			end
		end
	end

endmodule

//--- rtl/frame_control.sv
// turn sequencer; walks init, idle, register, apply, draw and done for each accepted command
`timescale 1ns/1ps

module frame_control
	import game_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  action_valid,
	input  logic  draw_done,
	output turn_t turn,
	output logic  action_take,
	output logic  turn_done
);

	typedef enum logic [2:0] {
		ST_INIT,
		ST_IDLE,
		ST_REG,
		ST_APPLY,
		ST_DRAW,
		ST_DONE
	} state_e;

	state_e state;
	state_e state_next;

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= ST_INIT;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			ST_INIT:
				state_next = ST_IDLE;
			ST_IDLE:
				if (action_valid)
					state_next = ST_REG;
			ST_REG:
				state_next = ST_APPLY;
			ST_APPLY:
				state_next = ST_DRAW;
			// sprite scan length depends on frame buffer back-pressure
			ST_DRAW:
				if (draw_done)
					state_next = ST_DONE;
			ST_DONE:
				state_next = ST_IDLE;
			default:
				state_next = ST_INIT;
		endcase
	end

	// step flags, done reuses idle since the character has nothing to do there
	always_comb
	begin
		turn = '0;
		case (state)
			ST_INIT:
				turn.init = 1'b1;
			ST_IDLE, ST_DONE:
				turn.idle = 1'b1;
			ST_REG:
				turn.reg_action = 1'b1;
			ST_APPLY:
				turn.apply_action = 1'b1;
			ST_DRAW:
				turn.draw_char = 1'b1;
			default:
				turn.init = 1'b1;
		endcase
	end

	// single cycle states give single cycle pulses
	assign action_take = (state == ST_REG);
	assign turn_done   = (state == ST_DONE);

endmodule

//--- rtl/game_pkg.sv
// shared types for the character game; imported by every RTL module that needs them
package game_pkg;

	// keypad buttons, one bit each
	typedef struct packed {
		logic attack;
		logic up;
		logic down;
		logic left;
		logic right;
	} buttons_t;

	// decoded command, encoding shared with the keypad side
	typedef enum logic [2:0] {
		ACT_NONE   = 3'd0,
		ACT_ATTACK = 3'd1,
		ACT_UP     = 3'd2,
		ACT_DOWN   = 3'd3,
		ACT_LEFT   = 3'd4,
		ACT_RIGHT  = 3'd5
	} action_e;

	typedef enum logic [1:0] {
		FACE_UP    = 2'd0,
		FACE_DOWN  = 2'd1,
		FACE_LEFT  = 2'd2,
		FACE_RIGHT = 2'd3
	} facing_e;

	// screen coordinate, x up to 319 and y up to 239
	typedef struct packed {
		logic [8:0] x;
		logic [7:0] y;
	} pos_t;

	// one frame buffer write
	typedef struct packed {
		logic [8:0] x;
		logic [7:0] y;
		logic [5:0] colour;
	} pixel_t;

	// step flags from the sequencer, one hot
	typedef struct packed {
		logic init;
		logic idle;
		logic reg_action;
		logic apply_action;
		logic draw_char;
	} turn_t;

	// sprite sheet is 16 rows of 64 columns
	typedef struct packed {
		logic [3:0] row;
		logic [5:0] col;
	} sprite_rc_t;

	// same word seen as a flat ROM index or as row and column
	typedef union packed {
		logic [9:0] flat;
		sprite_rc_t rc;
	} sprite_addr_u;

endpackage

//--- rtl/link_char.sv
// character state and sprite scan; moves on apply and streams 256 sprite pixels on draw
`timescale 1ns/1ps

`include "game_settings.svh"

module link_char
	import game_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  turn_t   turn,
	input  action_e action,
	input  logic    blocked,
	output pos_t    position,
	output facing_e facing,
	output logic    draw_done,
	output logic    pix_valid,
	output pixel_t  pix,
	input  logic    pix_ready
);

	action_e      cur_action;
	logic [5:0]   base_col;
	logic [7:0]   count;
	logic         addr_live;
	logic         advance;
	logic         issue;
	sprite_addr_u addr_next;
	sprite_addr_u rom_addr;
	sprite_addr_u addr_held;
	pos_t         pix_pos;
	logic [5:0]   rom_colour;

	// position, facing and which sprite of the sheet to use
	always_ff @(posedge clock)
	begin
		if (reset || turn.init)
		begin
			position.x <= 9'(`START_X);
			position.y <= 8'(`START_Y);
			facing     <= FACE_DOWN;
			base_col   <= 6'd0;
			cur_action <= ACT_NONE;
		end
		else if (turn.reg_action)
		begin
			cur_action <= action;
		end
		else if (turn.apply_action)
		begin
			// blocked steps still turn the character
			case (cur_action)
				ACT_UP:
				begin
					if (!blocked)
						position.y <= position.y - 8'd1;
					facing   <= FACE_UP;
					base_col <= 6'd32;
				end
				ACT_DOWN:
				begin
					if (!blocked)
						position.y <= position.y + 8'd1;
					facing   <= FACE_DOWN;
					base_col <= 6'd0;
				end
				ACT_LEFT:
				begin
					if (!blocked)
						position.x <= position.x - 9'd1;
					facing   <= FACE_LEFT;
					base_col <= 6'd16;
				end
				ACT_RIGHT:
				begin
					if (!blocked)
						position.x <= position.x + 9'd1;
					facing   <= FACE_RIGHT;
					base_col <= 6'd48;
				end
				// attack and none only redraw
				default:
					base_col <= base_col;
			endcase
		end
	end

	// output stage moves when empty or when the writer takes the pixel
	assign advance = !pix_valid || pix_ready;
	assign issue   = turn.draw_char && addr_live && advance;

	// low counter bits walk the columns, high bits the rows
	always_comb
	begin
		addr_next.rc.row = count[7:4];
		addr_next.rc.col = base_col + 6'(count[3:0]);
		// on a stall the ROM re-reads the held address so its output stays put
		rom_addr = issue ? addr_next : addr_held;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count     <= 8'd0;
			addr_live <= 1'b0;
			pix_valid <= 1'b0;
			draw_done <= 1'b0;
		end
		else
		begin
			// last pixel leaves the output stage with nothing behind it
			draw_done <= turn.draw_char && !addr_live && pix_valid && pix_ready;
			if (turn.init || turn.idle)
			begin
				count     <= 8'd0;
				addr_live <= 1'b0;
			end
			else if (turn.apply_action)
			begin
				count     <= 8'd0;
				addr_live <= 1'b1;
			end
			else if (issue)
			begin
				count <= count + 8'd1;
				if (count == 8'hff)
					addr_live <= 1'b0;
			end
			if (advance)
				pix_valid <= issue;
		end
	end

	// screen coordinate travels beside the ROM read
	always_ff @(posedge clock)
	begin
		addr_held <= rom_addr;
		if (issue)
		begin
			pix_pos.x <= position.x + 9'(count[3:0]);
			pix_pos.y <= position.y + 8'(count[7:4]);
		end
	end

	sprite_rom rom_i (
		.clock   (clock),
		.address (rom_addr),
		.colour  (rom_colour)
	);

	// colour arrives one cycle after the address, aligned with pix_pos
	assign pix = {pix_pos, rom_colour};

endmodule

//--- rtl/link_top.sv
// top level; keypad capture, turn sequencer, character with collision check, frame buffer writer
`timescale 1ns/1ps

module link_top
	import game_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     cmd_req,
	input  buttons_t cmd_buttons,
	output logic     cmd_ack,
	output logic     fb_req,
	output pixel_t   fb_pix,
	input  logic     fb_ack,
	output pos_t     char_pos,
	output facing_e  char_facing,
	output logic     turn_done
);

	logic    action_valid;
	action_e action;
	logic    action_take;
	turn_t   turn;
	logic    draw_done;
	logic    blocked;
	logic    pix_valid;
	pixel_t  pix;
	logic    pix_ready;

	command_capture capture_i (
		.clock        (clock),
		.reset        (reset),
		.cmd_req      (cmd_req),
		.cmd_buttons  (cmd_buttons),
		.cmd_ack      (cmd_ack),
		.action_take  (action_take),
		.action_valid (action_valid),
		.action       (action)
	);

	frame_control control_i (
		.clock        (clock),
		.reset        (reset),
		.action_valid (action_valid),
		.draw_done    (draw_done),
		.turn         (turn),
		.action_take  (action_take),
		.turn_done    (turn_done)
	);

	// capture keeps the taken action until the next latch, which cannot land before apply ends
	collision_check collision_i (
		.position (char_pos),
		.action   (action),
		.blocked  (blocked)
	);

	link_char char_i (
		.clock     (clock),
		.reset     (reset),
		.turn      (turn),
		.action    (action),
		.blocked   (blocked),
		.position  (char_pos),
		.facing    (char_facing),
		.draw_done (draw_done),
		.pix_valid (pix_valid),
		.pix       (pix),
		.pix_ready (pix_ready)
	);

	pixel_writer writer_i (
		.clock     (clock),
		.reset     (reset),
		.pix_valid (pix_valid),
		.pix       (pix),
		.pix_ready (pix_ready),
		.fb_req    (fb_req),
		.fb_pix    (fb_pix),
		.fb_ack    (fb_ack)
	);

endmodule

//--- rtl/pixel_writer.sv
// frame buffer output side; one pixel buffer, drops transparent pixels, four-phase master
`timescale 1ns/1ps

`include "game_settings.svh"

module pixel_writer
	import game_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   pix_valid,
	input  pixel_t pix,
	output logic   pix_ready,
	output logic   fb_req,
	output pixel_t fb_pix,
	input  logic   fb_ack
);

	typedef enum logic [1:0] {
		WR_EMPTY,
		WR_REQ,
		WR_RELEASE
	} wr_state_e;

	wr_state_e state;
	logic      accept;
	logic      opaque;

	// buffer takes a pixel only when empty
	assign pix_ready = (state == WR_EMPTY);
	assign accept    = pix_valid && pix_ready;
	assign opaque    = (pix.colour != 6'(`TRANSPARENT));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= WR_EMPTY;
		end
		else
		begin
			case (state)
				// transparent pixels are taken and forgotten here
				WR_EMPTY:
					if (accept && opaque)
						state <= WR_REQ;
				WR_REQ:
					if (fb_ack)
						state <= WR_RELEASE;
				// no new request until the slave drops ack
				WR_RELEASE:
					if (!fb_ack)
						state <= WR_EMPTY;
				default:
					state <= WR_EMPTY;
			endcase
		end
	end

	// held pixel, stable for the whole request phase
	always_ff @(posedge clock)
	begin
		if (accept && opaque)
			fb_pix <= pix;
	end

	// req drops the cycle after ack is seen
	assign fb_req = (state == WR_REQ);

endmodule

//--- rtl/sprite_rom.sv
// registered sprite sheet of four 16x16 sprites side by side, contents built from a rule
`timescale 1ns/1ps

`include "game_settings.svh"

module sprite_rom
	import game_pkg::*;
(
	input  logic         clock,
	input  sprite_addr_u address,
	output logic [5:0]   colour
);

	logic [5:0] rom [0:1023];

	// flat index is row * 64 + column
	for (genvar i = 0; i < 1024; i++)
	begin : g_cell
		localparam int ROW  = i / 64;
		localparam int COL  = i % 64;
		localparam int CELL = COL % `SPRITE_SIZE;
		localparam bit EDGE = (ROW < `SPRITE_BORDER) ||
			(ROW >= `SPRITE_SIZE - `SPRITE_BORDER) ||
			(CELL < `SPRITE_BORDER) ||
			(CELL >= `SPRITE_SIZE - `SPRITE_BORDER);
		// solid interior, 10 for down up to 40 for right
		assign rom[i] = EDGE ? 6'(`TRANSPARENT) : 6'(10 + 10 * (COL / `SPRITE_SIZE));
	end

	always_ff @(posedge clock)
	begin
		colour <= rom[address.flat];
	end

endmodule

//--- sources.f
+incdir+include
rtl/game_pkg.sv
rtl/command_capture.sv
rtl/frame_control.sv
rtl/collision_check.sv
rtl/sprite_rom.sv
rtl/link_char.sv
rtl/pixel_writer.sv
rtl/link_top.sv
dv/link_checker.sv
dv/link_tb.sv
